// File: include/apu_consts.svh
`ifndef APU_CONSTS_SVH
`define APU_CONSTS_SVH

// register window of the audio and i/o block
// 4000h..401Fh, matched with the mask below
`define APU_WIN_BASE 16'h4000

// upper eleven address bits select the window
`define APU_WIN_MASK 16'hFFE0

// width of the offset field inside the window
// the offset values themselves are enumerated in apu_pkg
`define APU_OFF_W 5

// sprite data port of the picture unit
// every dma byte is written here
`define OAM_DATA_ADDR 16'h2004

// bytes per sprite dma, one full page
`define DMA_BYTES 256

`endif

// File: src/apu_pkg.sv
package apu_pkg;

    // sprite dma sequencer states
    // idle: cpu owns the bus
    // align: single dead cycle before the first read
    // read/write: one byte moved per pair
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ALIGN = 2'd1,
        READ  = 2'd2,
        WRITE = 2'd3
    } dma_state_t;

    // register offsets inside the 4000h window
    // only the ones this block decodes
    typedef enum logic [4:0] {
        // page register, write starts the dma
        OAMDMA = 5'h14,
        // controller 1, strobe on write, serial bit on read
        CTRL1  = 5'h16,
        // controller 2, read only here
        CTRL2  = 5'h17
    } reg_off_t;

endpackage

// File: src/oam_dma_fsm.sv
`timescale 1ns/1ps
`include "apu_consts.svh"

module oam_dma_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic [15:0]         cpu_addr_i,
    input  logic [7:0]          cpu_data_i,
    input  logic                cpu_rw_i,
    input  logic                cpu_rdy_i,
    input  logic                last_i,
    output logic                dma_en_o,
    output apu_pkg::dma_state_t state_o,
    output logic [7:0]          page_o,
    output logic                count_en_o,
    output logic                count_clr_o
);

    apu_pkg::dma_state_t state_q;
    apu_pkg::dma_state_t state_d;
    logic                win_hit;
    logic                start;

    // cpu write to 4014h, only while the cpu is actually running
    assign win_hit = (cpu_addr_i & `APU_WIN_MASK) == `APU_WIN_BASE;
    assign start   = win_hit && !cpu_rw_i && cpu_rdy_i
                     && cpu_addr_i[`APU_OFF_W-1:0] == apu_pkg::OAMDMA;

    always_comb begin
        state_d = state_q;
        case (state_q)
            apu_pkg::IDLE:  if (start) state_d = apu_pkg::ALIGN;
            apu_pkg::ALIGN: state_d = apu_pkg::READ;
            apu_pkg::READ:  state_d = apu_pkg::WRITE;
            // loop until the final byte has been written
            apu_pkg::WRITE: state_d = last_i ? apu_pkg::IDLE : apu_pkg::READ;
            default:        state_d = apu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= apu_pkg::IDLE;
            dma_en_o <= 1'b0;
        end else begin
            state_q <= state_d;
            // takeover level, set with the start and dropped after the last write
            if (state_q == apu_pkg::IDLE && start) begin
                dma_en_o <= 1'b1;
            end else if (state_q == apu_pkg::WRITE && last_i) begin
                dma_en_o <= 1'b0;
            end
        end
    end

    // source page, high address byte of every read
    always_ff @(posedge clk) begin
        if (state_q == apu_pkg::IDLE && start) begin
            page_o <= cpu_data_i;
        end
    end

    assign state_o = state_q;

    // counter cleared in the dead cycle, advanced once per write
    assign count_clr_o = state_q == apu_pkg::ALIGN;
    assign count_en_o  = state_q == apu_pkg::WRITE;

    // takeover level and sequencer must never disagree
    a_en_matches_state: assert property (
        @(posedge clk) disable iff (rst)
        dma_en_o == (state_q != apu_pkg::IDLE)
    );

endmodule

// File: src/dma_counter.sv
`timescale 1ns/1ps
`include "apu_consts.svh"

module dma_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic       clr_i,
    input  logic       count_en_i,
    output logic [7:0] byte_idx_o,
    output logic       last_o
);

    // index of the final byte of the page
    localparam logic [7:0] LAST_IDX = 8'(`DMA_BYTES - 1);

    logic [7:0] cnt_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (clr_i) begin
            // clear beats count
            cnt_q <= '0;
        end else if (count_en_i) begin
            // wrap back to zero after the final byte
            if (cnt_q == LAST_IDX) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 8'd1;
            end
        end
    end

    assign byte_idx_o = cnt_q;
    assign last_o     = cnt_q == LAST_IDX;

    // sequencer clears only in the dead cycle, never in a write cycle
    a_no_clr_with_count: assert property (
        @(posedge clk) disable iff (rst)
        !(clr_i && count_en_i)
    );

endmodule

// File: src/ctrl_port.sv
`timescale 1ns/1ps
`include "apu_consts.svh"

module ctrl_port (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] cpu_addr_i,
    input  logic [7:0]  cpu_data_i,
    input  logic        cpu_rw_i,
    input  logic [1:0]  ctrl_data_i,
    output logic [2:0]  ctrl_strobe_o,
    output logic [1:0]  ctrl_out_o,
    output logic [7:0]  rd_data_o,
    output logic        rd_hit_o
);

    logic win_hit;
    logic win_rd;
    logic win_wr;
    logic [`APU_OFF_W-1:0] off;

    assign win_hit = (cpu_addr_i & `APU_WIN_MASK) == `APU_WIN_BASE;
    assign win_rd  = win_hit && cpu_rw_i;
    assign win_wr  = win_hit && !cpu_rw_i;
    assign off     = cpu_addr_i[`APU_OFF_W-1:0];

    // control side: strobe latch, clock pulses, read-select flag
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_strobe_o <= '0;
            ctrl_out_o    <= '0;
            rd_hit_o      <= 1'b0;
        end else begin
            rd_hit_o <= win_rd;
            // clock lines only pulse for a single cycle
            ctrl_out_o <= '0;
            if (win_wr && off == apu_pkg::CTRL1) begin
                ctrl_strobe_o <= cpu_data_i[2:0];
            end
            if (win_rd && off == apu_pkg::CTRL1) begin
                ctrl_out_o[0] <= 1'b1;
            end
            if (win_rd && off == apu_pkg::CTRL2) begin
                ctrl_out_o[1] <= 1'b1;
            end
        end
    end

    // read data, zero unless a controller port was read
    always_ff @(posedge clk) begin
        rd_data_o <= '0;
        if (win_rd && off == apu_pkg::CTRL1) begin
            rd_data_o <= {7'h00, ctrl_data_i[0]};
        end else if (win_rd && off == apu_pkg::CTRL2) begin
            rd_data_o <= {7'h00, ctrl_data_i[1]};
        end
    end

    // only one controller is clocked per cpu read
    a_one_clock_line: assert property (
        @(posedge clk) disable iff (rst)
        ctrl_out_o != 2'b11
    );

endmodule

// File: src/bus_arbiter.sv
`timescale 1ns/1ps
`include "apu_consts.svh"

module bus_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                dma_en_i,
    input  apu_pkg::dma_state_t state_i,
    input  logic [7:0]          page_i,
    input  logic [7:0]          byte_idx_i,
    input  logic [15:0]         cpu_addr_i,
    input  logic [7:0]          cpu_data_i,
    input  logic                cpu_rw_i,
    input  logic                rdy_i,
    input  logic [7:0]          bus_data_i,
    input  logic [7:0]          rd_data_i,
    input  logic                rd_hit_i,
    output logic [15:0]         bus_addr_o,
    output logic [7:0]          bus_data_o,
    output logic                bus_rw_o,
    output logic [7:0]          cpu_data_o,
    output logic                cpu_rdy_o
);

    logic [7:0] dma_byte_q;

    // byte fetched in read, replayed in the following write
    always_ff @(posedge clk) begin
        if (state_i == apu_pkg::READ) begin
            dma_byte_q <= bus_data_i;
        end
    end

    // bus master select by dma state
    always_comb begin
        bus_addr_o = cpu_addr_i;
        bus_data_o = cpu_data_i;
        bus_rw_o   = cpu_rw_i;
        case (state_i)
            apu_pkg::READ: begin
                bus_addr_o = {page_i, byte_idx_i};
                bus_rw_o   = 1'b1;
            end
            apu_pkg::WRITE: begin
                bus_addr_o = `OAM_DATA_ADDR;
                bus_data_o = dma_byte_q;
                bus_rw_o   = 1'b0;
            end
            default: ;
        endcase
    end

    // cpu halted for the whole transfer
    assign cpu_rdy_o  = rdy_i && !dma_en_i;
    // register read from last cycle wins over the system bus
    assign cpu_data_o = rd_hit_i ? rd_data_i : bus_data_i;

    // every read is followed by a write of that same byte to the sprite port
    a_read_then_oam_write: assert property (
        @(posedge clk) disable iff (rst)
        state_i == apu_pkg::READ |=>
            state_i == apu_pkg::WRITE && !bus_rw_o
            && bus_addr_o == `OAM_DATA_ADDR && bus_data_o == $past(bus_data_i)
    );

endmodule

// File: src/apu_bus.sv
`timescale 1ns/1ps

module apu_bus (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] cpu_addr_i,
    input  logic [7:0]  cpu_data_i,
    input  logic        cpu_rw_i,
    input  logic        rdy_i,
    input  logic [7:0]  bus_data_i,
    input  logic [1:0]  ctrl_data_i,
    output logic [15:0] bus_addr_o,
    output logic [7:0]  bus_data_o,
    output logic        bus_rw_o,
    output logic [7:0]  cpu_data_o,
    output logic        cpu_rdy_o,
    output logic [2:0]  ctrl_strobe_o,
    output logic [1:0]  ctrl_out_o
);

    // dma sequencing
    logic                dma_en;
    apu_pkg::dma_state_t dma_state;
    logic [7:0]          page;
    logic                count_en;
    logic                count_clr;
    logic [7:0]          byte_idx;
    logic                last;

    // register read return
    logic [7:0] rd_data;
    logic       rd_hit;

    // start decode sees the gated ready, so a stalled cpu cannot start a dma
    oam_dma_fsm u_oam_dma_fsm (
        .clk         (clk),
        .rst         (rst),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_data_i  (cpu_data_i),
        .cpu_rw_i    (cpu_rw_i),
        .cpu_rdy_i   (cpu_rdy_o),
        .last_i      (last),
        .dma_en_o    (dma_en),
        .state_o     (dma_state),
        .page_o      (page),
        .count_en_o  (count_en),
        .count_clr_o (count_clr)
    );

    dma_counter u_dma_counter (
        .clk        (clk),
        .rst        (rst),
        .clr_i      (count_clr),
        .count_en_i (count_en),
        .byte_idx_o (byte_idx),
        .last_o     (last)
    );

    // controller registers at 4016h/4017h
    ctrl_port u_ctrl_port (
        .clk           (clk),
        .rst           (rst),
        .cpu_addr_i    (cpu_addr_i),
        .cpu_data_i    (cpu_data_i),
        .cpu_rw_i      (cpu_rw_i),
        .ctrl_data_i   (ctrl_data_i),
        .ctrl_strobe_o (ctrl_strobe_o),
        .ctrl_out_o    (ctrl_out_o),
        .rd_data_o     (rd_data),
        .rd_hit_o      (rd_hit)
    );

    bus_arbiter u_bus_arbiter (
        .clk        (clk),
        .rst        (rst),
        .dma_en_i   (dma_en),
        .state_i    (dma_state),
        .page_i     (page),
        .byte_idx_i (byte_idx),
        .cpu_addr_i (cpu_addr_i),
        .cpu_data_i (cpu_data_i),
        .cpu_rw_i   (cpu_rw_i),
        .rdy_i      (rdy_i),
        .bus_data_i (bus_data_i),
        .rd_data_i  (rd_data),
        .rd_hit_i   (rd_hit),
        .bus_addr_o (bus_addr_o),
        .bus_data_o (bus_data_o),
        .bus_rw_o   (bus_rw_o),
        .cpu_data_o (cpu_data_o),
        .cpu_rdy_o  (cpu_rdy_o)
    );

endmodule

// File: verif/tb_apu_bus.sv
`timescale 1ns/1ps
`include "apu_consts.svh"

module tb_apu_bus;

    // parking address of the cpu when idle or halted
    localparam logic [15:0] IDLE_ADDR = 16'h8000;
    // upper bound on the cpu halt before giving up
    localparam int DMA_TIMEOUT = 2 * `DMA_BYTES + 64;

    logic        clk;
    logic        rst;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_wdata;
    logic        cpu_rw;
    logic        rdy;
    logic [7:0]  bus_rdata;
    logic [1:0]  ctrl_data;
    logic [15:0] bus_addr;
    logic [7:0]  bus_wdata;
    logic        bus_rw;
    logic [7:0]  cpu_rdata;
    logic        cpu_rdy;
    logic [2:0]  ctrl_strobe;
    logic [1:0]  ctrl_out;

    int          errors;
    int          checks;
    int          dma_bytes;
    bit          timed_out;
    logic [31:0] seed;

    apu_bus UUT (
        .clk           (clk),
        .rst           (rst),
        .cpu_addr_i    (cpu_addr),
        .cpu_data_i    (cpu_wdata),
        .cpu_rw_i      (cpu_rw),
        .rdy_i         (rdy),
        .bus_data_i    (bus_rdata),
        .ctrl_data_i   (ctrl_data),
        .bus_addr_o    (bus_addr),
        .bus_data_o    (bus_wdata),
        .bus_rw_o      (bus_rw),
        .cpu_data_o    (cpu_rdata),
        .cpu_rdy_o     (cpu_rdy),
        .ctrl_strobe_o (ctrl_strobe),
        .ctrl_out_o    (ctrl_out)
    );

    // memory model, low address byte xor a5h on every read
    assign bus_rdata = bus_rw ? (bus_addr[7:0] ^ 8'hA5) : 8'h00;

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // lcg, upper bits used since the low ones repeat quickly
    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // inputs change 2 ns after the edge
    task automatic advance();
        @(posedge clk);
        #2;
    endtask

    task automatic drive_idle();
        cpu_addr  = IDLE_ADDR;
        cpu_wdata = 8'h00;
        cpu_rw    = 1'b1;
        ctrl_data = 2'b00;
    endtask

    // write cycle, strobe checked one cycle later
    task automatic write_reg(input logic [15:0] addr, input logic [7:0] data,
                             input logic [15:0] exp);
        advance();
        cpu_addr  = addr;
        cpu_wdata = data;
        cpu_rw    = 1'b0;
        advance();
        drive_idle();
        @(negedge clk);
        check_value("ctrl_strobe_o", 16'(ctrl_strobe), exp);
    endtask

    // window read, data and clock pulse show up one cycle later
    task automatic read_reg(input logic [15:0] addr, input logic [7:0] ctrl,
                            input logic [15:0] exp);
        logic [31:0] rnd;
        logic [1:0]  bits;
        logic [1:0]  pulse;
        logic [15:0] want;
        bits = ctrl[1:0];
        want = exp;
        // 0Fh asks for random controller bits
        if (ctrl == 8'h0F) begin
            rnd  = lcg_next();
            bits = rnd[17:16];
            want = (addr == 16'h4016) ? 16'(bits[0]) :
                   (addr == 16'h4017) ? 16'(bits[1]) : 16'h0000;
        end
        // 4016h clocks port 1, 4017h port 2
        pulse = (addr == 16'h4016) ? 2'b01 : (addr == 16'h4017) ? 2'b10 : 2'b00;
        advance();
        cpu_addr  = addr;
        cpu_rw    = 1'b1;
        ctrl_data = bits;
        advance();
        drive_idle();
        @(negedge clk);
        check_value("cpu_data_o", 16'(cpu_rdata), want);
        check_value("ctrl_out_o", 16'(ctrl_out), 16'(pulse));
        // pulse gone again
        advance();
        @(negedge clk);
        check_value("ctrl_out_o", 16'(ctrl_out), 16'h0000);
    endtask

    // read outside the window, system bus data straight through
    task automatic fetch_bus(input logic [15:0] addr, input logic [15:0] exp);
        advance();
        cpu_addr = addr;
        cpu_rw   = 1'b1;
        @(negedge clk);
        check_value("bus_addr_o", bus_addr, addr);
        check_value("cpu_data_o", 16'(cpu_rdata), exp);
    endtask

    task automatic idle_cycles(input logic [15:0] count, input logic level,
                               input logic [15:0] exp);
        for (int i = 0; i < int'(count); i++) begin
            advance();
            drive_idle();
            rdy = level;
            @(negedge clk);
            check_value("cpu_rdy_o", 16'(cpu_rdy), exp);
            // no takeover, bus still mirrors the cpu
            check_value("bus_addr_o", bus_addr, IDLE_ADDR);
        end
    endtask

    task automatic dma_transfer(input logic [15:0] addr, input logic [7:0] page,
                                input logic [15:0] exp);
        int         low_cnt;
        int         writes;
        logic [7:0] idx;
        low_cnt = 0;
        writes  = 0;
        idx     = 8'h00;
        advance();
        cpu_addr  = addr;
        cpu_wdata = page;
        cpu_rw    = 1'b0;
        @(negedge clk);
        check_value("cpu_rdy_o", 16'(cpu_rdy), 16'h0001);
        advance();
        drive_idle();
        @(negedge clk);
        // dead cycle first, then read/write pairs until the cpu is released
        while (!cpu_rdy && low_cnt < DMA_TIMEOUT) begin
            if (low_cnt == 0) begin
                check_value("bus_addr_o", bus_addr, IDLE_ADDR);
            end else if (low_cnt % 2 == 1) begin
                check_value("bus_addr_o", bus_addr, {page, idx});
                check_value("bus_rw_o", 16'(bus_rw), 16'h0001);
            end else begin
                check_value("bus_addr_o", bus_addr, `OAM_DATA_ADDR);
                check_value("bus_rw_o", 16'(bus_rw), 16'h0000);
                // byte read from page:idx comes back as idx ^ a5h
                check_value("bus_data_o", 16'(bus_wdata), 16'(idx ^ 8'hA5));
                idx = idx + 8'd1;
                writes++;
            end
            low_cnt++;
            advance();
            drive_idle();
            @(negedge clk);
        end
        dma_bytes += writes;
        if (!cpu_rdy) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: CPU still halted %0d cycles after the DMA start", DMA_TIMEOUT);
        end else begin
            check_value("cpu_rdy_o low cycles", 16'(low_cnt), exp);
            check_value("dma write count", 16'(writes), 16'(`DMA_BYTES));
            check_value("bus_addr_o", bus_addr, IDLE_ADDR);
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  ctrl;
        logic [15:0] exp;
        clk       = 1'b0;
        rst       = 1'b1;
        rdy       = 1'b1;
        errors    = 0;
        checks    = 0;
        dma_bytes = 0;
        timed_out = 1'b0;
        seed      = 32'ha579;
        drive_idle();
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        // out of reset, cpu owns the bus
        check_value("ctrl_out_o", 16'(ctrl_out), 16'h0000);
        check_value("ctrl_strobe_o", 16'(ctrl_strobe), 16'h0000);
        check_value("cpu_rdy_o", 16'(cpu_rdy), 16'(rdy));
        check_value("bus_addr_o", bus_addr, cpu_addr);
        fd = $fopen("verif/apu_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open verif/apu_testdata.txt for reading");
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c %h %h %h %h", op, addr, data, ctrl, exp);
                // comment and blank lines skipped
                if (line.getc(0) != "#" && n == 5) begin
                    case (op)
                        "W": write_reg(addr, data, exp);
                        "R": read_reg(addr, ctrl, exp);
                        "B": fetch_bus(addr, exp);
                        "D": dma_transfer(addr, data, exp);
                        "Q": idle_cycles(addr, data[0], exp);
                        default: begin
                            errors++;
                            $display("unknown opcode %c in the test data", op);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        $display("checks: %0d, errors: %0d, dma bytes: %0d", checks, errors, dma_bytes);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verif/apu_testdata.txt
# op addr data ctrl exp, hex fields; W write, R read, B bus read, D dma, Q idle
# R ctrl 0F = random bits, D exp = halt cycles, Q addr = cycles and data = rdy_i
Q 0004 01 00 0001
W 4016 05 00 0005
W 0300 02 00 0005
R 4016 00 01 0001
R 4016 00 02 0000
R 4017 00 02 0001
R 4017 00 01 0000
W 4016 FA 00 0002
R 4016 00 0F 0000
R 4017 00 0F 0000
R 4016 00 0F 0000
R 4017 00 0F 0000
R 4016 00 0F 0000
R 4017 00 0F 0000
R 4015 00 03 0000
R 401F 00 03 0000
B 0312 00 00 00B7
B 6C40 00 00 00E5
W 0123 07 00 0002
D 4014 02 00 0201
B 02FF 00 00 005A
Q 0003 00 00 0000
W 4014 07 00 0002
Q 0020 00 00 0000
Q 0004 01 00 0001
D 4014 07 00 0201
R 4016 00 01 0001

// File: sources.f
+incdir+include
src/apu_pkg.sv
src/oam_dma_fsm.sv
src/dma_counter.sv
src/ctrl_port.sv
src/bus_arbiter.sv
src/apu_bus.sv
verif/tb_apu_bus.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_apu_bus
RTL_TOP   ?= apu_bus
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Simulation failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
